//--- Makefile
# Verilator build and run of the timestamp capture testbench

VERILATOR ?= verilator
TOP       ?= tb_ts_capture
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+common
common/ts_pkg.sv
verilog/rtc_counter.sv
verilog/pulse_cross_clock.sv
timestamp/timestamp_snapshot.sv
timestamp/ts_message_collector.sv
verilog/ts_capture_top.sv
sim/ts_capture_props.sv
sim/tb_ts_capture.sv

//--- common/ts_defs.svh
// counter divider, microsecond wrap, message length, crossing delay

`ifndef TS_DEFS_SVH
`define TS_DEFS_SVH

// tclk cycles per microsecond tick
`define RTC_USEC_DIV 8

// usec count that rolls over into seconds
`define USEC_WRAP 1000000

// bytes per timestamp message
`define TS_MSG_BYTES 8

// extra resync stages on the crossing ack path
`define PCC_EXTRA_DLY 1

`endif

//--- common/ts_pkg.sv
// timestamp struct, send state enum, receive state enum

package ts_pkg;

    // captured time, seconds plus microseconds
    typedef struct packed {
        logic [31:0] sec;   // whole seconds
        logic [19:0] usec;  // 0 .. 999999
    } ts_time_t;

    // snapshot sender
    typedef enum logic {
        SND_IDLE  = 1'b0,   // waiting for busy to drop
        SND_BYTES = 1'b1    // streaming message bytes
    } snd_state_e;

    // message collector
    typedef enum logic {
        RX_IDLE  = 1'b0,    // no burst in progress
        RX_BYTES = 1'b1     // shifting in a burst
    } rx_state_e;

endpackage

//--- sim/tb_ts_capture.sv
// testbench for the timestamp capture path with file-driven tests, time model and timeout

`timescale 1ns/1ps
`include "ts_defs.svh"

module tb_ts_capture import ts_pkg::*; ();
    localparam int MAX_TESTS  = 32;
    localparam int SETTLE     = 40;  // longer than a round trip plus a burst
    localparam int BUSY_MAX   = 10;  // longest crossing round trip, rst cycles
    localparam int IDLE_CHECK = 50;

    logic     rst  = 1'b0;  // system clock
    logic     tclk = 1'b0;  // time clock
    logic     sclk;         // reset
    logic     snap;
    logic     load;
    ts_time_t load_time;
    logic     pre_stb;
    logic     ts_valid;
    ts_time_t ts;

    logic [8*24-1:0] t_name [MAX_TESTS];
    int              t_sec  [MAX_TESTS];
    int              t_usec [MAX_TESTS];
    int              t_wait [MAX_TESTS];  // rst cycles before the snap
    int              t_gap  [MAX_TESTS];  // second snap, 0 = none
    int              t_msgs [MAX_TESTS];  // expected ts_valid pulses
    int              n_tests   = 0;
    string           cur_name  = "startup";
    int              errors    = 0;
    int              checks    = 0;
    int              valid_cnt = 0;
    int              pre_cnt   = 0;
    ts_time_t        last_ts   = '0;
    int              cycle_cnt = 0;
    int              limit     = 0;       // 0 until the tests are known
    logic [16:0]     lfsr_state;
    int              m_pre;               // model prescaler
    logic [31:0]     m_sec;
    logic [19:0]     m_usec;

    always #5 rst = ~rst;     // 10 ns
    always #3.5 tclk = ~tclk; // 7 ns

    ts_capture_top uut (
        .rst       (rst),
        .sclk      (sclk),
        .tclk      (tclk),
        .snap      (snap),
        .load      (load),
        .load_time (load_time),
        .pre_stb   (pre_stb),
        .ts_valid  (ts_valid),
        .ts        (ts)
    );

    // reference time, one usec per divider period, seconds carry at the wrap
    always @(posedge tclk or posedge sclk) begin
        if (sclk) begin
            m_pre  <= 0;
            m_sec  <= '0;
            m_usec <= '0;
        end else if (load) begin
            m_pre  <= 0;
            m_sec  <= load_time.sec;
            m_usec <= load_time.usec;
        end else if (m_pre == `RTC_USEC_DIV - 1) begin
            m_pre <= 0;
            if (m_usec == 20'(`USEC_WRAP - 1)) begin
                m_usec <= '0;
                m_sec  <= m_sec + 32'd1;
            end else begin
                m_usec <= m_usec + 20'd1;
            end
        end else begin
            m_pre <= m_pre + 1;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge rst) begin
        if (!sclk) begin
            if (ts_valid) begin
                valid_cnt <= valid_cnt + 1;
                last_ts   <= ts;
            end
            if (pre_stb) begin
                pre_cnt <= pre_cnt + 1;
            end
        end
    end

    always @(posedge rst) begin
        cycle_cnt <= cycle_cnt + 1;
        if (limit > 0 && cycle_cnt >= limit) begin
            $display("ERROR: timeout after %0d system cycles in test %0s", cycle_cnt, cur_name);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};  // x^17 + x^14 + 1
    endfunction

    function automatic longint unsigned time_total(input logic [31:0] s, input logic [19:0] u);
        return 64'(s) * 64'(`USEC_WRAP) + 64'(u);
    endfunction

    function automatic longint unsigned model_now();
        return time_total(m_sec, m_usec);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | 32'(lfsr_state[0]);
        end
    endtask

    task automatic read_tests();
        int              fd;
        int              code;
        logic [8*160-1:0] line;
        logic [8*24-1:0]  nm;
        int              a;
        int              b;
        int              c;
        int              d;
        int              e;
        fd = $fopen("sim/ts_tests.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                code = $fgets(line, fd);
                if (code != 0) begin
                    code = $sscanf(line, "%s %d %d %d %d %d", nm, a, b, c, d, e);
                    if (code == 6) begin  // comments and blank lines fall out here
                        t_name[n_tests] = nm;
                        t_sec[n_tests]  = a;
                        t_usec[n_tests] = b;
                        t_wait[n_tests] = c;
                        t_gap[n_tests]  = d;
                        t_msgs[n_tests] = e;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_load(input int sec_v, input int usec_v);
        @(negedge tclk);
        load           = 1'b1;
        load_time.sec  = 32'(sec_v);
        load_time.usec = 20'(usec_v);
        @(negedge tclk);
        load = 1'b0;
    endtask

    task automatic check_window(input longint unsigned ref_t, input ts_time_t got);
        longint unsigned got_t;
        got_t = time_total(got.sec, got.usec);
        checks++;
        assert (got_t >= ref_t && got_t <= ref_t + 64'd1) else begin
            $display("CHECK FAILED %0s: time expected %0d..%0d us, actual %0d us",
                     cur_name, ref_t, ref_t + 64'd1, got_t);
            errors++;
        end
        checks++;
        assert (32'(got.usec) < `USEC_WRAP) else begin
            $display("CHECK FAILED %0s: usec expected below %0d, actual %0d",
                     cur_name, `USEC_WRAP, got.usec);
            errors++;
        end
    endtask

    task automatic check_idle();
        cur_name = "reset_idle";
        checks++;
        assert (pre_stb == 1'b0 && ts_valid == 1'b0) else begin
            $display("CHECK FAILED %0s: pre_stb/ts_valid expected 0/0, actual %0b/%0b",
                     cur_name, pre_stb, ts_valid);
            errors++;
        end
        repeat (IDLE_CHECK) @(negedge rst);  // nothing may move without a snap
        checks++;
        assert (pre_cnt == 0 && valid_cnt == 0) else begin
            $display("CHECK FAILED %0s: pulses expected 0, actual pre_stb %0d ts_valid %0d",
                     cur_name, pre_cnt, valid_cnt);
            errors++;
        end
    endtask

    task automatic run_test(input int i);
        int              idle;
        int              base;
        longint unsigned m_first;
        longint unsigned m_second;
        longint unsigned m_ref;
        take_bits(4, idle);
        repeat (idle) @(negedge rst);
        cur_name = $sformatf("%0s", t_name[i]);
        apply_load(t_sec[i], t_usec[i]);
        repeat (t_wait[i]) @(negedge rst);
        base     = valid_cnt;
        m_second = 64'd0;
        @(negedge rst);
        snap    = 1'b1;
        m_first = model_now();  // time at the edge where snap is driven
        for (int k = 1; k <= t_gap[i]; k++) begin
            @(negedge rst);
            snap = (k == t_gap[i]);
            if (k == t_gap[i]) begin
                m_second = model_now();
            end
        end
        @(negedge rst);
        snap = 1'b0;
        while (valid_cnt - base < t_msgs[i]) @(negedge rst);
        repeat (SETTLE) @(negedge rst);  // room for a stray extra message
        checks++;
        assert (valid_cnt - base == t_msgs[i]) else begin
            $display("CHECK FAILED %0s: ts_valid count expected %0d, actual %0d",
                     cur_name, t_msgs[i], valid_cnt - base);
            errors++;
        end
        if (t_msgs[i] > 0) begin
            // a late second snap wins, an early one dies in the busy crossing
            m_ref = (t_gap[i] > BUSY_MAX) ? m_second : m_first;
            check_window(m_ref, last_ts);
        end
    endtask

    initial begin
        int total_wait;
        snap       = 1'b0;
        load       = 1'b0;
        load_time  = '0;
        sclk       = 1'b1;
        lfsr_state = 17'd73538;
        read_tests();
        if (n_tests == 0) begin
            $display("ERROR: no test vectors could be read from sim/ts_tests.txt");
            $display("Something failed");
            $finish;
        end else begin
            total_wait = 0;
            for (int i = 0; i < n_tests; i++) begin
                total_wait += t_wait[i];
            end
            limit = total_wait + 400 * n_tests + 100;  // 100 for reset and idle check
            repeat (5) @(negedge rst);
            sclk = 1'b0;
            check_idle();
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            errors = errors + uut.i_snapshot.i_props.prop_fails;
            $display("checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

//--- sim/ts_capture_props.sv
// concurrent checks on the snapshot sender and its bind

`timescale 1ns/1ps
`include "ts_defs.svh"

module ts_capture_props import ts_pkg::*; (
    input logic       rst,      // system clock
    input logic       sclk,     // async reset
    input logic       pre_stb,
    input logic       ts_send,
    input logic [7:0] ts_data,
    input snd_state_e state
);
    logic [3:0] send_run;       // ts_send high cycles before this one
    int         prop_fails = 0;

    always_ff @(posedge rst or posedge sclk) begin
        if (sclk) begin
            send_run <= '0;
        end else if (ts_send) begin
            send_run <= send_run + 4'd1;
        end else begin
            send_run <= '0;
        end
    end

    // pre_stb hands the sender over to the burst
    a_pre_one: assert property (@(posedge rst) disable iff (sclk)
        pre_stb |=> !pre_stb && state == SND_BYTES)
        else begin
            $error("pre_stb not one cycle or burst not started");
            prop_fails++;
        end

    a_send_len: assert property (@(posedge rst) disable iff (sclk)
        ts_send |-> send_run < 4'(`TS_MSG_BYTES))
        else begin
            $error("ts_send longer than one message");
            prop_fails++;
        end

    // last byte goes out after the machine has dropped back to idle
    a_pad_zero: assert property (@(posedge rst) disable iff (sclk)
        (ts_send && state == SND_IDLE) |-> ts_data == 8'h00)
        else begin
            $error("pad byte not zero");
            prop_fails++;
        end

endmodule

bind timestamp_snapshot ts_capture_props i_props (
    .rst     (rst),
    .sclk    (sclk),
    .pre_stb (pre_stb),
    .ts_send (ts_send),
    .ts_data (ts_data),
    .state   (state)
);

//--- sim/ts_tests.txt
# name load_sec load_usec wait_cycles second_snap_gap expected_messages
# gap counts system cycles from the first snap and 0 means a single snap
zero_start 0 0 3 0 1
load_small 5 100 10 0 1
mid_second 1234 500000 25 0 1
usec_rollover 41 999999 20 0 1
near_rollover 7 999998 3 0 1
late_rollover 99999 999990 40 0 1
burst_cut 300 12345 15 13 1
busy_ignore 77 654321 8 1 1
two_snaps 500 700000 10 45 2
long_wait 2000000 42 60 0 1
big_seconds 2000000000 999000 12 0 1

//--- timestamp/timestamp_snapshot.sv
// time snapshot on a crossed snap strobe, sent out as an eight-byte burst

`timescale 1ns/1ps
`include "ts_defs.svh"

module timestamp_snapshot import ts_pkg::*; (
    input  logic       sclk,     // async reset, active high
    input  logic       rst,      // system clock
    input  logic       tclk,     // time clock
    input  ts_time_t   now,      // @tclk, running time
    input  logic       snap,     // @rst, one cycle
    output logic       pre_stb,  // one cycle before the burst
    output logic       ts_send,  // ts_data carries a byte
    output logic [7:0] ts_data   // s0 s1 s2 s3 u0 u1 u2 pad
);
    localparam logic [2:0] LAST_IDX = 3'(`TS_MSG_BYTES - 1);

    logic       snap_tclk;  // snap seen in tclk
    logic       busy;       // crossing round trip
    logic       busy_d;     // busy one rst cycle later
    ts_time_t   frozen;     // captured time, tclk domain
    snd_state_e state;
    logic [2:0] idx;        // byte being sent

    pulse_cross_clock i_snap_cross (
        .sclk      (sclk),
        .rst       (rst),
        .tclk      (tclk),
        .in_pulse  (snap),
        .out_pulse (snap_tclk),
        .busy      (busy)
    );

    always_ff @(posedge tclk) begin
        if (snap_tclk) begin
            frozen <= now;
        end
    end

    // busy falls well after the capture, frozen is settled here
    assign pre_stb = busy_d & ~busy;

    always_ff @(posedge rst or posedge sclk) begin
        if (sclk) begin
            busy_d  <= 1'b0;
            state   <= SND_IDLE;
            idx     <= '0;
            ts_send <= 1'b0;
        end else begin
            busy_d  <= busy;
            ts_send <= (state == SND_BYTES) && !snap;  // new snap cuts the burst
            if (pre_stb) begin
                state <= SND_BYTES;
                idx   <= '0;
            end else if (state == SND_BYTES) begin
                idx <= idx + 1'b1;
                if (snap || idx == LAST_IDX) begin
                    state <= SND_IDLE;
                end
            end
        end
    end

    always_ff @(posedge rst) begin
        if (state == SND_BYTES) begin
            case (idx)
                3'd0:    ts_data <= frozen.sec[7:0];
                3'd1:    ts_data <= frozen.sec[15:8];
                3'd2:    ts_data <= frozen.sec[23:16];
                3'd3:    ts_data <= frozen.sec[31:24];
                3'd4:    ts_data <= frozen.usec[7:0];
                3'd5:    ts_data <= frozen.usec[15:8];
                3'd6:    ts_data <= {4'h0, frozen.usec[19:16]};  // top nibble only
                default: ts_data <= 8'h00;                        // pad
            endcase
        end
    end

endmodule

//--- timestamp/ts_message_collector.sv
// collector that rebuilds a timestamp from a complete eight-byte burst

`timescale 1ns/1ps
`include "ts_defs.svh"

module ts_message_collector import ts_pkg::*; (
    input  logic       sclk,      // async reset, active high
    input  logic       rst,       // system clock
    input  logic       pre_stb,   // burst about to start
    input  logic       ts_send,   // byte on ts_data
    input  logic [7:0] ts_data,
    output logic       ts_valid,  // one cycle, ts updated
    output ts_time_t   ts
);
    localparam logic [3:0] MSG_LEN = 4'(`TS_MSG_BYTES);

    rx_state_e   state;
    logic [3:0]  cnt;       // bytes taken in this burst
    logic [63:0] asm_q;     // first byte lands in bits 7:0
    logic        msg_done;  // burst ended with full length

    assign msg_done = (state == RX_BYTES) && !ts_send && (cnt == MSG_LEN);

    always_ff @(posedge rst or posedge sclk) begin
        if (sclk) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            ts_valid <= 1'b0;
        end else begin
            ts_valid <= msg_done;
            if (pre_stb) begin
                state <= RX_IDLE;
                cnt   <= '0;
            end else begin
                case (state)
                    RX_IDLE: begin
                        if (ts_send) begin
                            state <= RX_BYTES;
                            cnt   <= 4'd1;  // first byte
                        end
                    end
                    default: begin
                        if (ts_send) begin
                            cnt <= cnt + 1'b1;
                        end else begin
                            state <= RX_IDLE;  // short burst dropped here
                            cnt   <= '0;
                        end
                    end
                endcase
            end
        end
    end

    // shift right so byte order matches the sender
    always_ff @(posedge rst) begin
        if (ts_send) begin
            asm_q <= {ts_data, asm_q[63:8]};
        end
        if (msg_done) begin
            ts.sec  <= asm_q[31:0];
            ts.usec <= asm_q[51:32];
        end
    end

endmodule

//--- verilog/pulse_cross_clock.sv
// single pulse crossing from the system clock to tclk with a busy level back

`timescale 1ns/1ps
`include "ts_defs.svh"

module pulse_cross_clock #(
    parameter int EXTRA_DLY = `PCC_EXTRA_DLY  // extra ack stages past two
) (
    input  logic sclk,       // async reset, active high
    input  logic rst,        // source clock
    input  logic tclk,       // destination clock
    input  logic in_pulse,   // @rst, one cycle
    output logic out_pulse,  // @tclk, one cycle
    output logic busy        // @rst, round trip pending
);
    localparam int ACK_W = EXTRA_DLY + 2;

    logic             req;       // request flag, source side
    logic [1:0]       req_sync;  // req resynced to tclk
    logic             req_seen;  // req_sync[1] one tclk later
    logic [ACK_W-1:0] ack_sync;  // ack resynced back to rst

    // request held until the ack returns, then until the ack clears
    assign busy      = req | ack_sync[ACK_W-1];
    assign out_pulse = req_sync[1] & ~req_seen;  // rising edge of req

    always_ff @(posedge rst or posedge sclk) begin
        if (sclk) begin
            req      <= 1'b0;
            ack_sync <= '0;
        end else begin
            ack_sync <= {ack_sync[ACK_W-2:0], req_sync[1]};
            if (in_pulse && !busy) begin
                req <= 1'b1;                 // pulses while busy are lost
            end else if (ack_sync[ACK_W-1]) begin
                req <= 1'b0;                 // tclk side has it
            end
        end
    end

    always_ff @(posedge tclk or posedge sclk) begin
        if (sclk) begin
            req_sync <= '0;
            req_seen <= 1'b0;
        end else begin
            req_sync <= {req_sync[0], req};
            req_seen <= req_sync[1];
        end
    end

endmodule

//--- verilog/rtc_counter.sv
// loadable seconds and microseconds real-time counter in the tclk domain

`timescale 1ns/1ps
`include "ts_defs.svh"

module rtc_counter import ts_pkg::*; (
    input  logic     tclk,       // time clock
    input  logic     sclk,       // async reset, active high
    input  logic     load,       // @tclk, replace time
    input  ts_time_t load_time,  // @tclk
    output ts_time_t now         // @tclk, running time
);
    localparam int               PRE_W     = $clog2(`RTC_USEC_DIV + 1);
    localparam logic [PRE_W-1:0] PRE_LAST  = PRE_W'(`RTC_USEC_DIV - 1);
    localparam logic [19:0]      USEC_LAST = 20'(`USEC_WRAP - 1);

    logic [PRE_W-1:0] pre;        // prescaler, tclk cycles
    logic             usec_tick;  // one usec elapsed
    logic             usec_wrap;  // last usec of the second

    assign usec_tick = (pre == PRE_LAST);
    assign usec_wrap = (now.usec == USEC_LAST);

    always_ff @(posedge tclk or posedge sclk) begin
        if (sclk) begin
            pre <= '0;
            now <= '0;
        end else if (load) begin
            pre <= '0;              // restart the usec phase
            now <= load_time;
        end else begin
            if (usec_tick) begin
                pre <= '0;
            end else begin
                pre <= pre + 1'b1;
            end
            if (usec_tick) begin
                if (usec_wrap) begin
                    now.usec <= '0;
                    now.sec  <= now.sec + 1'b1;  // carry into seconds
                end else begin
                    now.usec <= now.usec + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/ts_capture_top.sv
// top level with counter, snapshot sender and message collector

`timescale 1ns/1ps

module ts_capture_top import ts_pkg::*; (
    input  logic     rst,        // system clock
    input  logic     sclk,       // async reset, active high
    input  logic     tclk,       // time clock
    input  logic     snap,       // @rst, capture request
    input  logic     load,       // @tclk
    input  ts_time_t load_time,  // @tclk
    output logic     pre_stb,    // burst about to start
    output logic     ts_valid,   // new ts
    output ts_time_t ts
);
    ts_time_t   now;      // @tclk running time
    logic       ts_send;
    logic [7:0] ts_data;

    rtc_counter i_rtc (
        .tclk      (tclk),
        .sclk      (sclk),
        .load      (load),
        .load_time (load_time),
        .now       (now)
    );

    timestamp_snapshot i_snapshot (
        .sclk    (sclk),
        .rst     (rst),
        .tclk    (tclk),
        .now     (now),
        .snap    (snap),
        .pre_stb (pre_stb),
        .ts_send (ts_send),
        .ts_data (ts_data)
    );

    ts_message_collector i_collector (
        .sclk     (sclk),
        .rst      (rst),
        .pre_stb  (pre_stb),
        .ts_send  (ts_send),
        .ts_data  (ts_data),
        .ts_valid (ts_valid),
        .ts       (ts)
    );

endmodule
